//--- rrLogPkg.sv
/*
  rrLog shared definitions: channel counts, payload widths,
  buffer depths and almost-full thresholds, and the log record type
*/
`default_nettype none

package rrLogPkg;

  // channels per source
  localparam int chanCntA = 2;
  localparam int chanCntB = 1;
  localparam int chanCnt  = chanCntA + chanCntB;

  // logb payload width of a single channel
  localparam int chanWidthA = 8;
  localparam int chanWidthB = 12;

  localparam int dataWidthA = chanCntA * chanWidthA;
  localparam int dataWidthB = chanCntB * chanWidthB;
  localparam int dataWidth  = dataWidthA + dataWidthB;

  // encoder buffer
  localparam int logDepth      = 8;
  localparam int almfulHiLevel = 6;
  localparam int almfulLoLevel = 4;

  // decoder buffer
  localparam int rplyDepth     = 4;
  localparam int rplyFullLevel = 3;

  // one record per cycle with any strobe, A in the low bits
  typedef struct packed {
    logic [chanCnt-1:0]   logbValid;
    logic [chanCnt-1:0]   logeValid;
    logic [dataWidth-1:0] logbData;
  } logRecordT;

endpackage

`default_nettype wire

//--- rrLoggingBusIf.sv
/*
  logging bus: begin/end strobes with begin payload from a source,
  two almost-full levels back from the logger
*/
`default_nettype none

interface rrLoggingBusIf #(
  parameter int logbChannelCnt = 1,
  parameter int logeChannelCnt = 1,
  parameter int logbDataWidth  = 8
);

  // strobes and payload from the source
  logic [logbChannelCnt-1:0] logbValid;
  logic [logbDataWidth-1:0]  logbData;
  logic [logeChannelCnt-1:0] logeValid;

  // back-pressure from the logger
  logic logbAlmfulHi;
  logic logbAlmfulLo;

  modport P (
    output logbValid,
    output logbData,
    output logeValid,
    input  logbAlmfulHi,
    input  logbAlmfulLo
  );

  modport C (
    input  logbValid,
    input  logbData,
    input  logeValid,
    output logbAlmfulHi,
    output logbAlmfulLo
  );

endinterface

`default_nettype wire

//--- rrReplayBusIf.sv
/*
  replay bus: per-channel replay strobes with begin payload,
  per-channel almost-full back from the replayed design
*/
`default_nettype none

interface rrReplayBusIf #(
  parameter int logbChannelCnt = 1,
  parameter int logeChannelCnt = 1,
  parameter int logbDataWidth  = 8
);

  // strobes and payload towards the replayed design
  logic [logbChannelCnt-1:0] valid;
  logic [logbChannelCnt-1:0] logbValid;
  logic [logeChannelCnt-1:0] logeValid;
  logic [logbDataWidth-1:0]  logbData;

  // one bit per channel
  logic [logbChannelCnt-1:0] almful;

  modport P (
    output valid,
    output logbValid,
    output logeValid,
    output logbData,
    input  almful
  );

  modport C (
    input  valid,
    input  logbValid,
    input  logeValid,
    input  logbData,
    output almful
  );

endinterface

`default_nettype wire

//--- rrLoggingBusGroup2.sv
/*
  merges two logging buses into one, A in the low bits,
  and hands the almost-full levels back to both sources
*/
`default_nettype none

module rrLoggingBusGroup2
  import rrLogPkg::*;
(
  rrLoggingBusIf.C inA,
  rrLoggingBusIf.C inB,
  rrLoggingBusIf.P out
);

  localparam int aLogbCnt = inA.logbChannelCnt;
  localparam int bLogbCnt = inB.logbChannelCnt;
  localparam int aLogeCnt = inA.logeChannelCnt;
  localparam int bLogeCnt = inB.logeChannelCnt;
  localparam int aWidth   = inA.logbDataWidth;
  localparam int bWidth   = inB.logbDataWidth;

  // elaboration checks
  if (aLogbCnt + bLogbCnt != out.logbChannelCnt) begin : gLogbCntChk
    $error("logb count mismatch: inA %0d, inB %0d, out %0d",
      aLogbCnt, bLogbCnt, out.logbChannelCnt);
  end
  if (aLogeCnt + bLogeCnt != out.logeChannelCnt) begin : gLogeCntChk
    $error("loge count mismatch: inA %0d, inB %0d, out %0d",
      aLogeCnt, bLogeCnt, out.logeChannelCnt);
  end
  if (aWidth + bWidth != out.logbDataWidth) begin : gWidthChk
    $error("logb data width mismatch: inA %0d, inB %0d, out %0d",
      aWidth, bWidth, out.logbDataWidth);
  end
  // per-channel payload widths of the two sources
  if ((aWidth != aLogbCnt * chanWidthA) || (bWidth != bLogbCnt * chanWidthB)) begin : gChanChk
    $error("channel width mismatch: inA %0d/%0d, inB %0d/%0d",
      aWidth, aLogbCnt, bWidth, bLogbCnt);
  end

  assign out.logbValid = {inB.logbValid, inA.logbValid};
  assign out.logbData  = {inB.logbData, inA.logbData};
  assign out.logeValid = {inB.logeValid, inA.logeValid};

  // same levels seen by both sources
  assign inA.logbAlmfulHi = out.logbAlmfulHi;
  assign inB.logbAlmfulHi = out.logbAlmfulHi;
  assign inA.logbAlmfulLo = out.logbAlmfulLo;
  assign inB.logbAlmfulLo = out.logbAlmfulLo;

endmodule

`default_nettype wire

//--- rrReplayBusUngroup2.sv
/*
  splits a combined replay bus into A and B by channel and payload width,
  gathers their per-channel almost-full back into the combined bus
*/
`default_nettype none

module rrReplayBusUngroup2
  import rrLogPkg::*;
(
  rrReplayBusIf.C in,
  rrReplayBusIf.P outA,
  rrReplayBusIf.P outB
);

  localparam int aCnt     = outA.logbChannelCnt;
  localparam int bCnt     = outB.logbChannelCnt;
  localparam int aLogeCnt = outA.logeChannelCnt;
  localparam int bLogeCnt = outB.logeChannelCnt;
  localparam int aWidth   = outA.logbDataWidth;
  localparam int bWidth   = outB.logbDataWidth;

  // elaboration checks
  if (aCnt + bCnt != in.logbChannelCnt) begin : gLogbCntChk
    $error("logb count mismatch: in %0d, outA %0d, outB %0d",
      in.logbChannelCnt, aCnt, bCnt);
  end
  if (aLogeCnt + bLogeCnt != in.logeChannelCnt) begin : gLogeCntChk
    $error("loge count mismatch: in %0d, outA %0d, outB %0d",
      in.logeChannelCnt, aLogeCnt, bLogeCnt);
  end
  if (aWidth + bWidth != in.logbDataWidth) begin : gWidthChk
    $error("logb data width mismatch: in %0d, outA %0d, outB %0d",
      in.logbDataWidth, aWidth, bWidth);
  end
  if ((aWidth != aCnt * chanWidthA) || (bWidth != bCnt * chanWidthB)) begin : gChanChk
    $error("channel width mismatch: outA %0d/%0d, outB %0d/%0d",
      aWidth, aCnt, bWidth, bCnt);
  end

  // low channels and low payload to A
  assign outA.valid     = in.valid[0 +: aCnt];
  assign outA.logbValid = in.logbValid[0 +: aCnt];
  assign outA.logeValid = in.logeValid[0 +: aLogeCnt];
  assign outA.logbData  = in.logbData[0 +: aWidth];

  assign outB.valid     = in.valid[aCnt +: bCnt];
  assign outB.logbValid = in.logbValid[aCnt +: bCnt];
  assign outB.logeValid = in.logeValid[aLogeCnt +: bLogeCnt];
  assign outB.logbData  = in.logbData[aWidth +: bWidth];

  assign in.almful = {outB.almful, outA.almful};

endmodule

`default_nettype wire

//--- rrLogEncoder.sv
/*
  log encoder: packs every cycle with a strobe into a record, buffers up to
  eight records, raises two almost-full levels and serves a read strobe
*/
`default_nettype none

module rrLogEncoder
  import rrLogPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  rrLoggingBusIf.C  logBus,
  input  logic      logRdEn,
  output logic      logOutValid,
  output logRecordT logOut,
  output logic      logOverflow
);

  localparam int ptrW = $clog2(logDepth);
  localparam int cntW = $clog2(logDepth + 1);

  if ((logBus.logbChannelCnt != chanCnt) || (logBus.logeChannelCnt != chanCnt) ||
      (logBus.logbDataWidth != dataWidth)) begin : gBusChk
    $error("logging bus does not match the record: %0d/%0d/%0d",
      logBus.logbChannelCnt, logBus.logeChannelCnt, logBus.logbDataWidth);
  end

  logRecordT       mem [logDepth];
  logRecordT       rec;
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            anyStrobe;
  logic            full;
  logic            wrEn;
  logic            rdEn;

  function automatic logic [ptrW-1:0] incPtr(input logic [ptrW-1:0] ptr);
    return (ptr == ptrW'(logDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rec.logbValid = logBus.logbValid;
  assign rec.logeValid = logBus.logeValid;
  assign rec.logbData  = logBus.logbData;

  assign anyStrobe = (|logBus.logbValid) || (|logBus.logeValid);
  assign full      = (count == cntW'(logDepth));
  // full is judged before the edge, a read in the same cycle does not help
  assign wrEn      = anyStrobe && !full;
  assign rdEn      = logRdEn && (count != '0);

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= rec;
    end
  end

  always_ff @(posedge clk) begin
    if (rdEn) begin
      logOut <= mem[rdPtr];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr       <= '0;
      rdPtr       <= '0;
      count       <= '0;
      logOutValid <= 1'b0;
      logOverflow <= 1'b0;
    end else begin
      if (wrEn) begin
        wrPtr <= incPtr(wrPtr);
      end
      if (rdEn) begin
        rdPtr <= incPtr(rdPtr);
      end
      count       <= count + cntW'(wrEn) - cntW'(rdEn);
      logOutValid <= rdEn;
      // sticky until reset
      if (anyStrobe && full) begin
        logOverflow <= 1'b1;
      end
    end
  end

  // levels follow the registered fill count
  assign logBus.logbAlmfulHi = (count >= cntW'(almfulHiLevel));
  assign logBus.logbAlmfulLo = (count >= cntW'(almfulLoLevel));

endmodule

`default_nettype wire

//--- rrReplayDecoder.sv
/*
  replay decoder: buffers incoming records and issues the oldest one as
  one-cycle replay strobes once none of its channels is almost full
*/
`default_nettype none

module rrReplayDecoder
  import rrLogPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  logic      rplyIn,
  input  logRecordT rplyData,
  output logic      rplyAlmful,
  rrReplayBusIf.P   rplyBus
);

  localparam int ptrW = $clog2(rplyDepth);
  localparam int cntW = $clog2(rplyDepth + 1);

  if ((rplyBus.logbChannelCnt != chanCnt) || (rplyBus.logeChannelCnt != chanCnt) ||
      (rplyBus.logbDataWidth != dataWidth)) begin : gBusChk
    $error("replay bus does not match the record: %0d/%0d/%0d",
      rplyBus.logbChannelCnt, rplyBus.logeChannelCnt, rplyBus.logbDataWidth);
  end

  logRecordT          mem [rplyDepth];
  logRecordT          head;
  logic [ptrW-1:0]    wrPtr;
  logic [ptrW-1:0]    rdPtr;
  logic [cntW-1:0]    count;
  logic [chanCnt-1:0] headChans;
  logic               wrEn;
  logic               issue;

  function automatic logic [ptrW-1:0] incPtr(input logic [ptrW-1:0] ptr);
    return (ptr == ptrW'(rplyDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wrEn = rplyIn && (count != cntW'(rplyDepth));
  assign head = mem[rdPtr];

  // channels the head record touches
  assign headChans = head.logbValid | head.logeValid;
  assign issue     = (count != '0) && ((headChans & rplyBus.almful) == '0);

  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrPtr] <= rplyData;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      rplyBus.logbData <= head.logbData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr             <= '0;
      rdPtr             <= '0;
      count             <= '0;
      rplyBus.valid     <= '0;
      rplyBus.logbValid <= '0;
      rplyBus.logeValid <= '0;
    end else begin
      if (wrEn) begin
        wrPtr <= incPtr(wrPtr);
      end
      if (issue) begin
        rdPtr <= incPtr(rdPtr);
      end
      count <= count + cntW'(wrEn) - cntW'(issue);
      // strobes last a single cycle
      rplyBus.valid     <= issue ? headChans : '0;
      rplyBus.logbValid <= issue ? head.logbValid : '0;
      rplyBus.logeValid <= issue ? head.logeValid : '0;
    end
  end

  assign rplyAlmful = (count >= cntW'(rplyFullLevel));

endmodule

`default_nettype wire

//--- rrLogTop.sv
/*
  rrLog top: logging path for sources A and B into the record buffer,
  replay path from records back out to the A and B replay ports
*/
`default_nettype none

module rrLogTop
  import rrLogPkg::*;
(
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [chanCntA-1:0]   logbValidA,
  input  logic [dataWidthA-1:0] logbDataA,
  input  logic [chanCntA-1:0]   logeValidA,
  input  logic [chanCntB-1:0]   logbValidB,
  input  logic [dataWidthB-1:0] logbDataB,
  input  logic [chanCntB-1:0]   logeValidB,
  output logic                  logAlmfulHi,
  output logic                  logAlmfulLo,
  output logic                  logOverflow,
  input  logic                  logRdEn,
  output logic                  logOutValid,
  output logRecordT             logOut,
  input  logic                  rplyIn,
  input  logRecordT             rplyData,
  output logic                  rplyAlmful,
  output logic [chanCntA-1:0]   rplyValidA,
  output logic [chanCntA-1:0]   rplyLogbValidA,
  output logic [chanCntA-1:0]   rplyLogeValidA,
  output logic [dataWidthA-1:0] rplyDataA,
  input  logic [chanCntA-1:0]   rplyChanAlmfulA,
  output logic [chanCntB-1:0]   rplyValidB,
  output logic [chanCntB-1:0]   rplyLogbValidB,
  output logic [chanCntB-1:0]   rplyLogeValidB,
  output logic [dataWidthB-1:0] rplyDataB,
  input  logic [chanCntB-1:0]   rplyChanAlmfulB
);

  rrLoggingBusIf #(chanCntA, chanCntA, dataWidthA) logBusA ();
  rrLoggingBusIf #(chanCntB, chanCntB, dataWidthB) logBusB ();
  rrLoggingBusIf #(chanCnt, chanCnt, dataWidth)    logBus ();

  rrReplayBusIf #(chanCnt, chanCnt, dataWidth)    rplyBus ();
  rrReplayBusIf #(chanCntA, chanCntA, dataWidthA) rplyBusA ();
  rrReplayBusIf #(chanCntB, chanCntB, dataWidthB) rplyBusB ();

  // logging side
  assign logBusA.logbValid = logbValidA;
  assign logBusA.logbData  = logbDataA;
  assign logBusA.logeValid = logeValidA;
  assign logBusB.logbValid = logbValidB;
  assign logBusB.logbData  = logbDataB;
  assign logBusB.logeValid = logeValidB;
  // both sources get the same copy, A's drives the ports
  assign logAlmfulHi = logBusA.logbAlmfulHi;
  assign logAlmfulLo = logBusA.logbAlmfulLo;

  rrLoggingBusGroup2 uGroup (.inA(logBusA), .inB(logBusB), .out(logBus));

  rrLogEncoder uEncoder (
    .clk, .arstN, .logBus, .logRdEn, .logOutValid, .logOut, .logOverflow
  );

  // replay side
  rrReplayDecoder uDecoder (.clk, .arstN, .rplyIn, .rplyData, .rplyAlmful, .rplyBus);

  rrReplayBusUngroup2 uUngroup (.in(rplyBus), .outA(rplyBusA), .outB(rplyBusB));

  assign rplyValidA      = rplyBusA.valid;
  assign rplyLogbValidA  = rplyBusA.logbValid;
  assign rplyLogeValidA  = rplyBusA.logeValid;
  assign rplyDataA       = rplyBusA.logbData;
  assign rplyBusA.almful = rplyChanAlmfulA;
  assign rplyValidB      = rplyBusB.valid;
  assign rplyLogbValidB  = rplyBusB.logbValid;
  assign rplyLogeValidB  = rplyBusB.logeValid;
  assign rplyDataB       = rplyBusB.logbData;
  assign rplyBusB.almful = rplyChanAlmfulB;

endmodule

`default_nettype wire

//--- rrLogAssertions.sv
/*
  concurrent checks on the rrLog top-level ports, bound into rrLogTop
*/
`default_nettype none

module rrLogAssertions
  import rrLogPkg::*;
(
  input logic                clk,
  input logic                arstN,
  input logic                logRdEn,
  input logic                logOutValid,
  input logic                logAlmfulHi,
  input logic                logAlmfulLo,
  input logic [chanCntA-1:0] rplyValidA,
  input logic [chanCntB-1:0] rplyValidB,
  input logic [chanCntA-1:0] rplyChanAlmfulA,
  input logic [chanCntB-1:0] rplyChanAlmfulB
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failCnt = 0;

  // one valid cycle per read pulse
  aReadPulse: assert property (@(posedge clk) disable iff (!arstN)
    logOutValid && !logRdEn |=> !logOutValid)
  else begin
    failCnt++;
    $error("logOutValid stayed high without a held read");
  end

  // issue is decided one cycle before the strobe
  aReplayAlmful: assert property (@(posedge clk) disable iff (!arstN)
    ({rplyValidB, rplyValidA} & $past({rplyChanAlmfulB, rplyChanAlmfulA})) == '0)
  else begin
    failCnt++;
    $error("replay strobe on a channel that was almost full");
  end

  aAlmfulOrder: assert property (@(posedge clk) disable iff (!arstN)
    logAlmfulHi |-> logAlmfulLo)
  else begin
    failCnt++;
    $error("high almost-full without low almost-full");
  end

endmodule

bind rrLogTop rrLogAssertions uAssertions (
  .clk,
  .arstN,
  .logRdEn,
  .logOutValid,
  .logAlmfulHi,
  .logAlmfulLo,
  .rplyValidA,
  .rplyValidB,
  .rplyChanAlmfulA,
  .rplyChanAlmfulB
);

`default_nettype wire

//--- tbRrLog.sv
/*
  rrLog testbench: directed tests of the logging and replay paths,
  checked against queue models of the expected records
*/
`default_nettype none

module tbRrLog
  import rrLogPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int maxCycles = 2000;
  localparam logic [chanCnt-1:0] maskA = chanCnt'((1 << chanCntA) - 1);
  localparam logic [chanCnt-1:0] maskB = ~maskA;

  logic                  clk = 1'b0;
  logic                  arstN;
  logic [chanCntA-1:0]   logbValidA;
  logic [dataWidthA-1:0] logbDataA;
  logic [chanCntA-1:0]   logeValidA;
  logic [chanCntB-1:0]   logbValidB;
  logic [dataWidthB-1:0] logbDataB;
  logic [chanCntB-1:0]   logeValidB;
  logic                  logAlmfulHi;
  logic                  logAlmfulLo;
  logic                  logOverflow;
  logic                  logRdEn;
  logic                  logOutValid;
  logRecordT             logOut;
  logic                  rplyIn;
  logRecordT             rplyData;
  logic                  rplyAlmful;
  logic [chanCntA-1:0]   rplyValidA;
  logic [chanCntA-1:0]   rplyLogbValidA;
  logic [chanCntA-1:0]   rplyLogeValidA;
  logic [dataWidthA-1:0] rplyDataA;
  logic [chanCntA-1:0]   rplyChanAlmfulA;
  logic [chanCntB-1:0]   rplyValidB;
  logic [chanCntB-1:0]   rplyLogbValidB;
  logic [chanCntB-1:0]   rplyLogeValidB;
  logic [dataWidthB-1:0] rplyDataB;
  logic [chanCntB-1:0]   rplyChanAlmfulB;

  // expected records, encoder readout and replay output
  logRecordT   logQ[$];
  logRecordT   rplyQ[$];
  int unsigned cycleCnt = 0;
  int unsigned rplySeen = 0;

  rrLogTop i_dut (.*);

  always #4 clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped on the first failure");
  endtask

  task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      failRun($sformatf("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt == maxCycles) begin
      failRun("timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // random record touching only the channels in chanMask
  function automatic logRecordT randRec(input logic [chanCnt-1:0] chanMask);
    logRecordT r;
    r.logbValid = chanCnt'($urandom) & chanMask;
    r.logeValid = chanCnt'($urandom) & chanMask;
    r.logbData  = dataWidth'($urandom);
    if ((r.logbValid | r.logeValid) == '0) begin
      r.logbValid = chanMask;
    end
    return r;
  endfunction

  // A takes the low channels and payload, B the rest
  task automatic logDrive(input logRecordT r);
    logbValidA = r.logbValid[chanCntA-1:0];
    logeValidA = r.logeValid[chanCntA-1:0];
    logbDataA  = r.logbData[dataWidthA-1:0];
    logbValidB = r.logbValid[chanCnt-1:chanCntA];
    logeValidB = r.logeValid[chanCnt-1:chanCntA];
    logbDataB  = r.logbData[dataWidth-1:dataWidthA];
  endtask

  task automatic logRead(input logRecordT exp);
    checkEq("logOutValid", logOutValid, 1'b0);
    logRdEn = 1'b1;
    step();
    logRdEn = 1'b0;
    checkEq("logOutValid", logOutValid, 1'b1);
    checkEq("logOut", logOut, exp);
    step();
    checkEq("logOutValid", logOutValid, 1'b0);
  endtask

  task automatic emptyRead();
    logRdEn = 1'b1;
    step();
    logRdEn = 1'b0;
    checkEq("logOutValid", logOutValid, 1'b0);
    step();
    checkEq("logOutValid", logOutValid, 1'b0);
  endtask

  task automatic rplySend(input logRecordT r);
    while (rplyAlmful) begin
      step();
    end
    rplyData = r;
    rplyIn   = 1'b1;
    rplyQ.push_back(r);
    step();
    rplyIn = 1'b0;
  endtask

  task automatic waitReplay(input int unsigned target);
    int unsigned waited;
    waited = 0;
    while (rplySeen < target) begin
      if (waited >= 50) begin
        failRun("replay output did not arrive within 50 cycles");
      end else begin
        step();
        waited++;
      end
    end
  endtask

  always @(negedge clk) begin : replayMonitor
    logRecordT exp;
    if (arstN && ((rplyValidA != '0) || (rplyValidB != '0))) begin
      if (rplyQ.size() == 0) begin
        failRun("replay strobe seen while no record was pending");
      end else begin
        exp = rplyQ.pop_front();
        checkEq("rplyValidA", rplyValidA, exp.logbValid[chanCntA-1:0] |
          exp.logeValid[chanCntA-1:0]);
        checkEq("rplyLogbValidA", rplyLogbValidA, exp.logbValid[chanCntA-1:0]);
        checkEq("rplyLogeValidA", rplyLogeValidA, exp.logeValid[chanCntA-1:0]);
        checkEq("rplyDataA", rplyDataA, exp.logbData[dataWidthA-1:0]);
        checkEq("rplyValidB", rplyValidB, exp.logbValid[chanCnt-1:chanCntA] |
          exp.logeValid[chanCnt-1:chanCntA]);
        checkEq("rplyLogbValidB", rplyLogbValidB, exp.logbValid[chanCnt-1:chanCntA]);
        checkEq("rplyLogeValidB", rplyLogeValidB, exp.logeValid[chanCnt-1:chanCntA]);
        checkEq("rplyDataB", rplyDataB, exp.logbData[dataWidth-1:dataWidthA]);
        rplySeen++;
      end
    end
  end

  task automatic testReset();
    checkEq("logOutValid", logOutValid, 1'b0);
    checkEq("logAlmfulHi", logAlmfulHi, 1'b0);
    checkEq("logAlmfulLo", logAlmfulLo, 1'b0);
    checkEq("logOverflow", logOverflow, 1'b0);
    checkEq("rplyAlmful", rplyAlmful, 1'b0);
    checkEq("rplyValidA", rplyValidA, '0);
    checkEq("rplyValidB", rplyValidB, '0);
  endtask

  task automatic testGrouping();
    logRecordT r;
    for (int i = 0; i < 6; i++) begin
      r = randRec('1);
      logDrive(r);
      logQ.push_back(r);
      step();
    end
    logDrive('0);
    while (logQ.size() > 0) begin
      logRead(logQ.pop_front());
    end
    emptyRead();
  endtask

  task automatic testLevels();
    logRecordT r;
    for (int i = 1; i <= logDepth + 1; i++) begin
      r = randRec('1);
      logDrive(r);
      // the ninth record is dropped
      if (i <= logDepth) begin
        logQ.push_back(r);
      end
      step();
      checkEq("logAlmfulLo", logAlmfulLo, i >= almfulLoLevel);
      checkEq("logAlmfulHi", logAlmfulHi, i >= almfulHiLevel);
      checkEq("logOverflow", logOverflow, i > logDepth);
    end
    logDrive('0);
    while (logQ.size() > 0) begin
      logRead(logQ.pop_front());
    end
    emptyRead();
    checkEq("logOverflow", logOverflow, 1'b1);
    checkEq("logAlmfulLo", logAlmfulLo, 1'b0);
  endtask

  task automatic testReplay();
    for (int i = 0; i < 6; i++) begin
      rplySend(randRec('1));
    end
    waitReplay(6);
    checkEq("rplyAlmful", rplyAlmful, 1'b0);
  endtask

  task automatic testBackPressure();
    rplyChanAlmfulB = '1;
    rplySend(randRec(maskB));
    rplySend(randRec(maskA));
    rplySend(randRec(maskA));
    checkEq("rplyAlmful", rplyAlmful, 1'b1);
    // head flags channel 2 and must stay put
    repeat (6) step();
    checkEq("replay count while held", rplySeen, 6);
    checkEq("rplyAlmful", rplyAlmful, 1'b1);
    rplyChanAlmfulB = '0;
    waitReplay(9);
    checkEq("rplyAlmful", rplyAlmful, 1'b0);
  endtask

  initial begin
    void'($urandom(488));
    arstN           = 1'b0;
    logRdEn         = 1'b0;
    rplyIn          = 1'b0;
    rplyData        = '0;
    rplyChanAlmfulA = '0;
    rplyChanAlmfulB = '0;
    logDrive('0);
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;
    testReset();
    testGrouping();
    testLevels();
    testReplay();
    testBackPressure();
    repeat (2) step();
    if (i_dut.uAssertions.failCnt == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("*** FAILED ***");
      $fatal(1, "concurrent assertion failures: %0d", i_dut.uAssertions.failCnt);
    end
  end

endmodule

`default_nettype wire

//--- rrLog.f
rrLogPkg.sv
rrLoggingBusIf.sv
rrReplayBusIf.sv
rrLoggingBusGroup2.sv
rrReplayBusUngroup2.sv
rrLogEncoder.sv
rrReplayDecoder.sv
rrLogTop.sv
rrLogAssertions.sv
tbRrLog.sv

//--- Bender.yml
package:
  name: rrLog

sources:
  # design
  - files:
      - rrLogPkg.sv
      - rrLoggingBusIf.sv
      - rrReplayBusIf.sv
      - rrLoggingBusGroup2.sv
      - rrReplayBusUngroup2.sv
      - rrLogEncoder.sv
      - rrReplayDecoder.sv
      - rrLogTop.sv
  # testbench
  - target: test
    files:
      - rrLogAssertions.sv
      - tbRrLog.sv
